/* logic/cpu_macros.svh */
/* CPU sizing macros
   Word width, register count, memory depths and instruction field positions */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define WORD_W      16
`define REG_COUNT   8
`define INSTR_DEPTH 64
`define TIM_DEPTH   64

// Instruction fields, opcode in the top bits
`define OPCODE_MSB  15
`define OPCODE_LSB  11
`define RD_LSB      8
`define RA_LSB      5

`endif

/* logic/cpu_pkg.sv */
/* CPU shared types
   Instruction format, opcodes, function codes, ALU ops and decoder output */
`default_nettype none
`include "cpu_macros.svh"

package cpu_pkg;

    typedef logic [`WORD_W-1:0]            word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    typedef enum logic [`OPCODE_MSB-`OPCODE_LSB:0] {
        OP_NOP   = 5'h00,
        OP_LW    = 5'h01,
        OP_SW    = 5'h02,
        OP_BIT   = 5'h03,
        OP_MOV   = 5'h04,
        OP_MOVI  = 5'h05,
        OP_ARITH = 5'h07,
        OP_BR    = 5'h09,
        OP_HALT  = 5'h1f
    } opcode_t;

    typedef logic [`RA_LSB-1:0] func_t;

    // ARITH codes, any code with bit 4 clear is add-immediate
    localparam func_t FN_ADDI  = 5'b00000;
    localparam func_t FN_ADD   = 5'b11111;
    localparam func_t FN_SUB   = 5'b10000;
    // BIT codes
    localparam func_t FN_OR    = 5'h00;
    localparam func_t FN_XOR   = 5'h01;
    localparam func_t FN_AND   = 5'h02;
    localparam func_t FN_NOT   = 5'h03;
    localparam func_t FN_LSHFT = 5'h04;
    localparam func_t FN_RSHFT = 5'h05;

    // Branch condition in imm8
    localparam logic [7:0] BR_ALWAYS = 8'h00;

    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t ra;
        func_t    func;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_PASS, ALU_ADD, ALU_SUB, ALU_OR,
        ALU_XOR, ALU_AND, ALU_NOT, ALU_LSHFT, ALU_RSHFT
    } alu_op_t;

    typedef struct packed {
        reg_idx_t   rd;
        reg_idx_t   ra;
        logic [7:0] imm8;
        logic [3:0] imm4;
        func_t      simm5;
        alu_op_t    alu_op;
        logic       has_we;
        logic       has_imm8;
        logic       has_imm4;
        logic       has_mem;
        logic       has_mem_we;
        logic       has_br;
        logic       is_halt;
    } decoded_t;

endpackage

`default_nettype wire

/* logic/mem_if.sv */
/* Data memory request channel
   Control requests one load or store, the memory unit reports busy and read data */
`timescale 1ns/1ps
`default_nettype none

interface mem_if;
    import cpu_pkg::*;

    logic  req;
    word_t addr;
    word_t wdata;
    logic  we;
    logic  busy;
    word_t rdata;

    modport requester (output req, addr, wdata, we, input busy, rdata);
    modport server (input req, addr, wdata, we, output busy, rdata);
endinterface

`default_nettype wire

/* logic/sync_ram.sv */
/* Single-port synchronous RAM
   Registered read, the output holds during a write cycle */
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
    parameter type payload_t = cpu_pkg::word_t,
    parameter int  DEPTH     = 64
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic                     we,
    input  payload_t                 wdata,
    output payload_t                 rdata
);
    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end
endmodule

`default_nettype wire

/* logic/instr_decoder.sv */
/* Instruction decoder
   Maps opcode and function code to the ALU op and control flags */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module instr_decoder (
    input  cpu_pkg::instr_t   instr,
    output cpu_pkg::decoded_t dec
);
    import cpu_pkg::*;

    always_comb begin
        dec        = '0;
        dec.rd     = instr.rd;
        dec.ra     = instr.ra;
        dec.imm8   = instr[`RD_LSB-1:0];
        dec.imm4   = instr.func[3:0];
        dec.simm5  = instr.func;
        dec.alu_op = ALU_NOP;

        case (instr.opcode)
            OP_HALT: dec.is_halt = 1'b1;
            OP_LW: begin
                dec.alu_op  = ALU_PASS;
                dec.has_mem = 1'b1;
                dec.has_we  = 1'b1;
            end
            OP_SW: begin
                dec.alu_op     = ALU_PASS;
                dec.has_mem    = 1'b1;
                dec.has_mem_we = 1'b1;
            end
            OP_MOV: begin
                dec.alu_op = ALU_PASS;
                dec.has_we = 1'b1;
            end
            OP_MOVI: begin
                dec.alu_op   = ALU_PASS;
                dec.has_imm8 = 1'b1;
                dec.has_we   = 1'b1;
            end
            OP_ARITH: begin
                dec.has_we = 1'b1;
                if (!instr.func[4]) begin
                    dec.alu_op   = ALU_ADD;
                    dec.has_imm4 = 1'b1;
                end else if (instr.func == FN_ADD) begin
                    dec.alu_op = ALU_ADD;
                end else if (instr.func == FN_SUB) begin
                    dec.alu_op = ALU_SUB;
                end else begin
                    dec.has_we = 1'b0;
                end
            end
            OP_BIT: begin
                dec.has_we = 1'b1;
                case (instr.func)
                    FN_OR:    dec.alu_op = ALU_OR;
                    FN_XOR:   dec.alu_op = ALU_XOR;
                    FN_AND:   dec.alu_op = ALU_AND;
                    FN_NOT:   dec.alu_op = ALU_NOT;
                    FN_LSHFT: dec.alu_op = ALU_LSHFT;
                    FN_RSHFT: dec.alu_op = ALU_RSHFT;
                    // Unknown bit op behaves as NOP
                    default:  dec.has_we = 1'b0;
                endcase
            end
            OP_BR: dec.has_br = 1'b1;
            default: ;
        endcase
    end
endmodule

`default_nettype wire

/* logic/alu.sv */
/* ALU
   Unsigned add and sub, bitwise ops, shifts and operand pass-through */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   c
);
    import cpu_pkg::*;

    always_comb begin
        case (op)
            // MOV, MOVI and the load/store address base
            ALU_PASS:  c = b;
            ALU_ADD:   c = a + b;
            ALU_SUB:   c = a - b;
            ALU_OR:    c = a | b;
            ALU_XOR:   c = a ^ b;
            ALU_AND:   c = a & b;
            ALU_NOT:   c = ~b;
            ALU_LSHFT: c = a << b;
            ALU_RSHFT: c = a >> b;
            default:   c = '0;
        endcase
    end
endmodule

`default_nettype wire

/* logic/reg_file.sv */
/* Register file
   Eight words, asynchronous read port and synchronous write port */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module reg_file (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::reg_idx_t rs,
    output cpu_pkg::word_t    rdata,
    input  logic              we,
    input  cpu_pkg::reg_idx_t ws,
    input  cpu_pkg::word_t    wdata
);
    import cpu_pkg::*;

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[ws] <= wdata;
        end
    end

    assign rdata = regs[rs];
endmodule

`default_nettype wire

/* logic/mem_unit.sv */
/* Memory unit
   Serves loads and stores from the TIM scratch RAM or over an APB master */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module mem_unit (
    input  logic           clk,
    input  logic           reset,
    mem_if.server          mem,
    output cpu_pkg::word_t paddr,
    output logic           pwrite,
    output logic           psel,
    output logic           penable,
    output cpu_pkg::word_t pwdata,
    input  cpu_pkg::word_t prdata,
    input  logic           pready
);
    import cpu_pkg::*;

    localparam int TIM_AW = $clog2(`TIM_DEPTH);

    typedef enum logic [1:0] {APB_IDLE, APB_SETUP, APB_ACCESS} apb_state_t;

    apb_state_t state;
    logic       tim_hit;
    logic       tim_sel;
    word_t      tim_rdata;
    word_t      apb_rdata;

    // Low addresses stay inside the core
    assign tim_hit  = mem.addr < `TIM_DEPTH;
    assign mem.busy = mem.req || (state != APB_IDLE);
    assign mem.rdata = tim_sel ? tim_rdata : apb_rdata;

    sync_ram #(
        .payload_t (word_t),
        .DEPTH     (`TIM_DEPTH)
    ) tim_ram (
        .clk   (clk),
        .addr  (mem.addr[TIM_AW-1:0]),
        .we    (mem.req && mem.we && tim_hit),
        .wdata (mem.wdata),
        .rdata (tim_rdata)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= APB_IDLE;
            tim_sel <= 1'b0;
            psel    <= 1'b0;
            penable <= 1'b0;
            pwrite  <= 1'b0;
        end else begin
            if (mem.req) begin
                tim_sel <= tim_hit;
            end
            case (state)
                APB_IDLE: begin
                    if (mem.req && !tim_hit) begin
                        psel   <= 1'b1;
                        pwrite <= mem.we;
                        state  <= APB_SETUP;
                    end
                end
                APB_SETUP: begin
                    penable <= 1'b1;
                    state   <= APB_ACCESS;
                end
                APB_ACCESS: begin
                    // Wait states last while pready is low
                    if (pready) begin
                        psel    <= 1'b0;
                        penable <= 1'b0;
                        pwrite  <= 1'b0;
                        state   <= APB_IDLE;
                    end
                end
                default: state <= APB_IDLE;
            endcase
        end
    end

    // Transfer address, write data and captured read data
    always_ff @(posedge clk) begin
        if (state == APB_IDLE && mem.req && !tim_hit) begin
            paddr  <= mem.addr;
            pwdata <= mem.wdata;
        end
        if (state == APB_ACCESS && pready) begin
            apb_rdata <= prdata;
        end
    end

    apb_access_stable: assert property (@(posedge clk) disable iff (reset)
        penable |-> psel && $stable(paddr));
endmodule

`default_nettype wire

/* logic/core_ctrl.sv */
/* Core control
   Multicycle fetch, operand read, memory and write-back FSM with PC and program RAM */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module core_ctrl (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            prog_we,
    input  logic [$clog2(`INSTR_DEPTH)-1:0] prog_addr,
    input  cpu_pkg::instr_t                 prog_data,
    mem_if.requester                        mem,
    output logic                            halted,
    output cpu_pkg::word_t                  dbg_pc
);
    import cpu_pkg::*;

    localparam int IA_W = $clog2(`INSTR_DEPTH);

    typedef enum logic [2:0] {ST_IF, ST_RD, ST_RA, ST_MEM, ST_WB, ST_HALT} state_t;

    state_t          state;
    word_t           pc;
    instr_t          instr;
    instr_t          ram_rdata;
    logic [IA_W-1:0] ram_addr;
    decoded_t        dec;
    reg_idx_t        reg_rs;
    word_t           reg_rdata;
    word_t           reg_wdata;
    logic            reg_we;
    word_t           opa;
    word_t           opb;
    word_t           alu_c;
    word_t           addr_base;
    logic            branch;

    // Program port owns the instruction RAM during reset
    assign ram_addr = reset ? prog_addr : pc[IA_W-1:0];

    sync_ram #(
        .payload_t (instr_t),
        .DEPTH     (`INSTR_DEPTH)
    ) instr_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .we    (reset && prog_we),
        .wdata (prog_data),
        .rdata (ram_rdata)
    );

    instr_decoder u_dec (.instr(instr), .dec(dec));

    // Single read port, rd first then ra
    assign reg_rs    = (state == ST_RD) ? dec.rd : dec.ra;
    assign reg_we    = dec.has_we && (state == ST_WB);
    assign reg_wdata = dec.has_mem ? mem.rdata : alu_c;

    reg_file u_regs (
        .clk   (clk),
        .reset (reset),
        .rs    (reg_rs),
        .rdata (reg_rdata),
        .we    (reg_we),
        .ws    (dec.rd),
        .wdata (reg_wdata)
    );

    alu u_alu (.op(dec.alu_op), .a(opa), .b(opb), .c(alu_c));

    // Request goes out in the read-ra step, base comes straight from the
    // register port there and from the ALU pass-through afterwards
    assign addr_base = (state == ST_RA) ? reg_rdata : alu_c;
    assign mem.req   = (state == ST_RA) && dec.has_mem;
    assign mem.addr  = addr_base + word_t'(dec.simm5);
    assign mem.wdata = opa;
    assign mem.we    = dec.has_mem_we;

    assign branch = dec.has_br && (dec.imm8 == BR_ALWAYS);
    assign dbg_pc = pc;

    always_ff @(posedge clk) begin
        if (state == ST_RD) begin
            opa <= reg_rdata;
        end
        if (state == ST_RA) begin
            if (dec.has_imm8) begin
                opb <= word_t'(dec.imm8);
            end else if (dec.has_imm4) begin
                opb <= word_t'(dec.imm4);
            end else begin
                opb <= reg_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // Write-back of a NOP gives the RAM one cycle to read word 0
            state  <= ST_WB;
            pc     <= '0;
            instr  <= '0;
            halted <= 1'b0;
        end else begin
            case (state)
                ST_IF: begin
                    instr <= ram_rdata;
                    state <= ST_RD;
                end
                ST_RD: state <= ST_RA;
                ST_RA: begin
                    if (branch) begin
                        pc <= opa;
                    end else if (pc < word_t'(`INSTR_DEPTH - 1)) begin
                        pc <= pc + 1'b1;
                    end
                    state <= dec.has_mem ? ST_MEM : ST_WB;
                end
                ST_MEM: begin
                    if (!mem.busy) begin
                        state <= ST_WB;
                    end
                end
                ST_WB: begin
                    if (dec.is_halt) begin
                        halted <= 1'b1;
                        state  <= ST_HALT;
                    end else begin
                        state <= ST_IF;
                    end
                end
                ST_HALT: state <= ST_HALT;
                default: state <= ST_IF;
            endcase
        end
    end

    // New request only after the memory unit has gone idle
    req_after_idle: assert property (@(posedge clk) disable iff (reset)
        mem.req |-> !$past(mem.busy));

    halt_is_sticky: assert property (@(posedge clk)
        halted && !reset |=> halted);
endmodule

`default_nettype wire

/* logic/cpu_top.sv */
/* CPU top level
   Core control and memory unit with program load port and APB master */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_top (
    input  logic                            clk,
    input  logic                            reset,
    // Program load, used during reset
    input  logic                            prog_we,
    input  logic [$clog2(`INSTR_DEPTH)-1:0] prog_addr,
    input  cpu_pkg::word_t                  prog_data,
    // APB master
    output cpu_pkg::word_t                  paddr,
    output logic                            pwrite,
    output logic                            psel,
    output logic                            penable,
    output cpu_pkg::word_t                  pwdata,
    input  cpu_pkg::word_t                  prdata,
    input  logic                            pready,
    // Status
    output logic                            halted,
    output cpu_pkg::word_t                  dbg_pc
);
    mem_if mem ();

    core_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .mem       (mem.requester),
        .halted    (halted),
        .dbg_pc    (dbg_pc)
    );

    mem_unit u_mem (
        .clk     (clk),
        .reset   (reset),
        .mem     (mem.server),
        .paddr   (paddr),
        .pwrite  (pwrite),
        .psel    (psel),
        .penable (penable),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );
endmodule

`default_nettype wire

/* tests/cpu_tb.sv */
/* CPU testbench
   Table-driven programs against the core, with an APB slave model on the bus */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_tb;
    import cpu_pkg::*;

    localparam int PA_W         = $clog2(`INSTR_DEPTH);
    localparam int NUM_TESTS    = 5;
    localparam int MAX_PROG     = 32;
    localparam int MAX_XFER     = 10;
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CYCLES  = 20;
    localparam int HALT_TIMEOUT = 3000;

    logic            clk;
    logic            reset;
    logic            prog_we;
    logic [PA_W-1:0] prog_addr;
    word_t           prog_data;
    word_t           paddr;
    logic            pwrite;
    logic            psel;
    logic            penable;
    word_t           pwdata;
    word_t           prdata;
    logic            pready;
    logic            halted;
    word_t           dbg_pc;

    // Test table
    string test_name [NUM_TESTS];
    word_t prog      [NUM_TESTS][MAX_PROG];
    int    prog_len  [NUM_TESTS];
    int    max_waits [NUM_TESTS];
    int    num_wr    [NUM_TESTS];
    word_t exp_waddr [NUM_TESTS][MAX_XFER];
    word_t exp_wdata [NUM_TESTS][MAX_XFER];
    int    num_rd    [NUM_TESTS];
    word_t exp_raddr [NUM_TESTS][MAX_XFER];
    word_t exp_pc    [NUM_TESTS];

    // Slave model state and observed transfers
    word_t       slave_mem [256];
    word_t       wr_addr_q [$];
    word_t       wr_data_q [$];
    word_t       rd_addr_q [$];
    logic        xfer_active;
    int          wait_left;
    word_t       xfer_addr;
    int          cur_max_waits;
    logic [31:0] lfsr_state;

    int errors;
    int checks;
    int failed_tests;

    cpu_top uut (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .paddr     (paddr),
        .pwrite    (pwrite),
        .psel      (psel),
        .penable   (penable),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .halted    (halted),
        .dbg_pc    (dbg_pc)
    );

    always #2 clk = ~clk;

    function automatic word_t encode(opcode_t op, reg_idx_t rd, reg_idx_t ra, func_t fn);
        return {op, rd, ra, fn};
    endfunction

    function automatic word_t encode_imm(opcode_t op, reg_idx_t rd, logic [7:0] imm8);
        return {op, rd, imm8};
    endfunction

    // Slave memory contents depend on the whole array address
    function automatic word_t fill_word(word_t a);
        return (a * 16'h0101) ^ 16'h3c5a;
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int random_waits(int limit);
        int value;
        int i;
        value = 0;
        for (i = 0; i < 3; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value % (limit + 1);
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%04h expected 0x%04h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_level(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_apb_write(word_t addr, word_t data, word_t addr_exp, word_t data_exp);
        checks++;
        if (addr !== addr_exp || data !== data_exp) begin
            $display("[ERROR] paddr/pwdata: got 0x%04h/0x%04h expected 0x%04h/0x%04h",
                     addr, data, addr_exp, data_exp);
            errors++;
        end
    endtask

    task automatic add_instr(int t, word_t w);
        prog[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    task automatic add_write(int t, word_t addr, word_t data);
        exp_waddr[t][num_wr[t]] = addr;
        exp_wdata[t][num_wr[t]] = data;
        num_wr[t]++;
    endtask

    task automatic add_read(int t, word_t addr);
        exp_raddr[t][num_rd[t]] = addr;
        num_rd[t]++;
    endtask

    task automatic build_table();
        int t;
        t = 0;
        test_name[t] = "movi_sw_apb";
        max_waits[t] = 0;
        add_instr(t, encode_imm(OP_MOVI, 3'd1, 8'ha5));
        add_instr(t, encode_imm(OP_MOVI, 3'd2, 8'h80));
        add_instr(t, encode(OP_SW, 3'd1, 3'd2, 5'd3));
        add_instr(t, encode(OP_HALT, 3'd0, 3'd0, 5'd0));
        add_write(t, 16'h0083, 16'h00a5);
        exp_pc[t] = 16'd4;

        // r1 = 0x3c, r2 = 0x0f, results stored from 0x90 up
        t = 1;
        test_name[t] = "alu_ops";
        max_waits[t] = 1;
        add_instr(t, encode_imm(OP_MOVI, 3'd1, 8'h3c));
        add_instr(t, encode_imm(OP_MOVI, 3'd2, 8'h0f));
        add_instr(t, encode_imm(OP_MOVI, 3'd7, 8'h90));
        add_instr(t, encode(OP_MOV, 3'd3, 3'd1, 5'd0));
        add_instr(t, encode(OP_ARITH, 3'd3, 3'd2, FN_ADD));
        add_instr(t, encode(OP_SW, 3'd3, 3'd7, 5'd0));
        add_instr(t, encode(OP_MOV, 3'd4, 3'd2, 5'd0));
        add_instr(t, encode(OP_ARITH, 3'd4, 3'd1, FN_SUB));
        add_instr(t, encode(OP_SW, 3'd4, 3'd7, 5'd1));
        add_instr(t, encode(OP_ARITH, 3'd1, 3'd0, 5'd5));
        add_instr(t, encode(OP_SW, 3'd1, 3'd7, 5'd2));
        add_instr(t, encode(OP_MOV, 3'd5, 3'd1, 5'd0));
        add_instr(t, encode(OP_BIT, 3'd5, 3'd2, FN_OR));
        add_instr(t, encode(OP_SW, 3'd5, 3'd7, 5'd3));
        add_instr(t, encode(OP_MOV, 3'd5, 3'd1, 5'd0));
        add_instr(t, encode(OP_BIT, 3'd5, 3'd2, FN_XOR));
        add_instr(t, encode(OP_SW, 3'd5, 3'd7, 5'd4));
        add_instr(t, encode(OP_MOV, 3'd5, 3'd1, 5'd0));
        add_instr(t, encode(OP_BIT, 3'd5, 3'd2, FN_AND));
        add_instr(t, encode(OP_SW, 3'd5, 3'd7, 5'd5));
        add_instr(t, encode(OP_BIT, 3'd5, 3'd2, FN_NOT));
        add_instr(t, encode(OP_SW, 3'd5, 3'd7, 5'd6));
        add_instr(t, encode_imm(OP_MOVI, 3'd6, 8'h03));
        add_instr(t, encode(OP_MOV, 3'd5, 3'd1, 5'd0));
        add_instr(t, encode(OP_BIT, 3'd5, 3'd6, FN_LSHFT));
        add_instr(t, encode(OP_SW, 3'd5, 3'd7, 5'd7));
        add_instr(t, encode(OP_MOV, 3'd5, 3'd1, 5'd0));
        add_instr(t, encode(OP_BIT, 3'd5, 3'd6, FN_RSHFT));
        add_instr(t, encode(OP_SW, 3'd5, 3'd7, 5'd8));
        add_instr(t, encode(OP_HALT, 3'd0, 3'd0, 5'd0));
        add_write(t, 16'h0090, 16'h004b);
        add_write(t, 16'h0091, 16'hffd3);
        add_write(t, 16'h0092, 16'h0041);
        add_write(t, 16'h0093, 16'h004f);
        add_write(t, 16'h0094, 16'h004e);
        add_write(t, 16'h0095, 16'h0001);
        add_write(t, 16'h0096, 16'hfff0);
        add_write(t, 16'h0097, 16'h0208);
        add_write(t, 16'h0098, 16'h0008);
        exp_pc[t] = 16'd30;

        // Store to TIM word 20, clobber r1, load back and export over APB
        t = 2;
        test_name[t] = "tim_round_trip";
        max_waits[t] = 0;
        add_instr(t, encode_imm(OP_MOVI, 3'd1, 8'h5d));
        add_instr(t, encode_imm(OP_MOVI, 3'd2, 8'h10));
        add_instr(t, encode(OP_SW, 3'd1, 3'd2, 5'd4));
        add_instr(t, encode_imm(OP_MOVI, 3'd1, 8'h00));
        add_instr(t, encode(OP_LW, 3'd3, 3'd2, 5'd4));
        add_instr(t, encode_imm(OP_MOVI, 3'd7, 8'ha0));
        add_instr(t, encode(OP_SW, 3'd3, 3'd7, 5'd0));
        add_instr(t, encode(OP_HALT, 3'd0, 3'd0, 5'd0));
        add_write(t, 16'h00a0, 16'h005d);
        exp_pc[t] = 16'd8;

        t = 3;
        test_name[t] = "apb_read_waits";
        max_waits[t] = 5;
        add_instr(t, encode_imm(OP_MOVI, 3'd2, 8'hc0));
        add_instr(t, encode(OP_LW, 3'd4, 3'd2, 5'd7));
        add_instr(t, encode(OP_SW, 3'd4, 3'd2, 5'd8));
        add_instr(t, encode(OP_LW, 3'd5, 3'd2, 5'd9));
        add_instr(t, encode(OP_SW, 3'd5, 3'd2, 5'd10));
        add_instr(t, encode(OP_HALT, 3'd0, 3'd0, 5'd0));
        add_read(t, 16'h00c7);
        add_read(t, 16'h00c9);
        add_write(t, 16'h00c8, fill_word(16'h00c7));
        add_write(t, 16'h00ca, fill_word(16'h00c9));
        exp_pc[t] = 16'd6;

        // Taken branch skips word 4 and the untaken one falls through
        t = 4;
        test_name[t] = "branch_halt";
        max_waits[t] = 2;
        add_instr(t, encode_imm(OP_MOVI, 3'd1, 8'h05));
        add_instr(t, encode_imm(OP_MOVI, 3'd2, 8'h77));
        add_instr(t, encode_imm(OP_MOVI, 3'd7, 8'hb0));
        add_instr(t, encode_imm(OP_BR, 3'd1, BR_ALWAYS));
        add_instr(t, encode(OP_SW, 3'd2, 3'd7, 5'd0));
        add_instr(t, encode(OP_SW, 3'd2, 3'd7, 5'd1));
        add_instr(t, encode_imm(OP_BR, 3'd1, 8'h01));
        add_instr(t, encode(OP_SW, 3'd2, 3'd7, 5'd2));
        add_instr(t, encode(OP_HALT, 3'd0, 3'd0, 5'd0));
        add_instr(t, encode(OP_SW, 3'd2, 3'd7, 5'd3));
        add_write(t, 16'h00b1, 16'h0077);
        add_write(t, 16'h00b2, 16'h0077);
        exp_pc[t] = 16'd9;
    endtask

    // APB slave model driving pready and prdata on the falling edge
    always @(negedge clk) begin
        if (reset) begin
            xfer_active = 1'b0;
            pready      = 1'b0;
        end else if (xfer_active) begin
            check_level("psel", psel, 1'b1);
            check_level("penable", penable, 1'b1);
            check_word("paddr", paddr, xfer_addr);
            if (wait_left == 0) begin
                pready      = 1'b1;
                xfer_active = 1'b0;
                if (pwrite) begin
                    wr_addr_q.push_back(paddr);
                    wr_data_q.push_back(pwdata);
                    slave_mem[paddr[7:0]] = pwdata;
                end else begin
                    rd_addr_q.push_back(paddr);
                    prdata = slave_mem[paddr[7:0]];
                end
            end else begin
                wait_left--;
            end
        end else begin
            pready = 1'b0;
            if (psel) begin
                // Setup phase
                check_level("penable", penable, 1'b0);
                xfer_addr   = paddr;
                wait_left   = random_waits(cur_max_waits);
                xfer_active = 1'b1;
            end
        end
    end

    task automatic check_reset_outputs();
        check_level("psel", psel, 1'b0);
        check_level("penable", penable, 1'b0);
        check_level("pwrite", pwrite, 1'b0);
        check_level("halted", halted, 1'b0);
        check_word("dbg_pc", dbg_pc, 16'h0000);
    endtask

    task automatic wait_halted(int t);
        int cycles;
        cycles = 0;
        while (halted !== 1'b1 && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("Timeout: core did not halt within %0d cycles in test %s",
                     HALT_TIMEOUT, test_name[t]);
            errors++;
        end
    endtask

    task automatic run_test(int t);
        int errors_before;
        int i;
        errors_before = errors;
        wr_addr_q.delete();
        wr_data_q.delete();
        rd_addr_q.delete();
        cur_max_waits = max_waits[t];
        @(negedge clk);
        reset = 1'b1;
        // Program words go in while the core is held in reset
        for (i = 0; i < prog_len[t]; i++) begin
            prog_we   = 1'b1;
            prog_addr = i[PA_W-1:0];
            prog_data = prog[t][i];
            @(negedge clk);
            check_reset_outputs();
        end
        prog_we = 1'b0;
        for (i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_reset_outputs();
        end
        reset = 1'b0;
        @(negedge clk);
        check_reset_outputs();

        wait_halted(t);
        // Bus stays quiet once halted
        for (i = 0; i < IDLE_CYCLES; i++) begin
            @(negedge clk);
            check_level("psel", psel, 1'b0);
        end
        check_level("halted", halted, 1'b1);
        check_word("dbg_pc", dbg_pc, exp_pc[t]);

        if (wr_addr_q.size() != num_wr[t]) begin
            $display("Test %s expected %0d APB writes but saw %0d",
                     test_name[t], num_wr[t], wr_addr_q.size());
            errors++;
        end else begin
            for (i = 0; i < num_wr[t]; i++) begin
                check_apb_write(wr_addr_q[i], wr_data_q[i], exp_waddr[t][i], exp_wdata[t][i]);
            end
        end
        if (rd_addr_q.size() != num_rd[t]) begin
            $display("Test %s expected %0d APB reads but saw %0d",
                     test_name[t], num_rd[t], rd_addr_q.size());
            errors++;
        end else begin
            for (i = 0; i < num_rd[t]; i++) begin
                check_word("paddr", rd_addr_q[i], exp_raddr[t][i]);
            end
        end

        if (errors == errors_before) begin
            $display("Test %0d %s ok", t, test_name[t]);
        end else begin
            $display("Test %0d %s FAILED with %0d errors", t, test_name[t],
                     errors - errors_before);
            failed_tests++;
        end
    endtask

    initial begin
        int i;
        clk           = 1'b0;
        reset         = 1'b1;
        prog_we       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        prdata        = '0;
        pready        = 1'b0;
        xfer_active   = 1'b0;
        wait_left     = 0;
        xfer_addr     = '0;
        cur_max_waits = 0;
        lfsr_state    = 32'h4b1b;
        errors        = 0;
        checks        = 0;
        failed_tests  = 0;
        for (i = 0; i < NUM_TESTS; i++) begin
            prog_len[i] = 0;
            num_wr[i]   = 0;
            num_rd[i]   = 0;
        end
        for (i = 0; i < 256; i++) begin
            slave_mem[i] = fill_word(word_t'(i));
        end
        build_table();

        for (i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 NUM_TESTS, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/cpu_pkg.sv
logic/mem_if.sv
logic/sync_ram.sv
logic/instr_decoder.sv
logic/alu.sv
logic/reg_file.sv
logic/mem_unit.sv
logic/core_ctrl.sv
logic/cpu_top.sv
tests/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_tb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vcpu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0
